//--- build.f
verilog/mem_bus_pkg.sv
verilog/mem_ctrl_pkg.sv
verilog/bus_adapter.sv
verilog/cache.sv
verilog/arbiter.sv
verilog/cacheline_adaptor.sv
verilog/mem_hier_top.sv
dv/mem_hier_tb.sv

//--- dv/mem_hier_tb.sv
`timescale 1ns/1ps

module mem_hier_tb
    import mem_bus_pkg::*;
();

    localparam word_t FILL_KEY     = 32'h5a5a_c3c3;   // initial memory word = addr ^ key
    localparam int    NUM_ACCESSES = 11;
    localparam int    MISS_CYCLES  = 2 * BEATS_PER_LINE * (3 + 2) + 30;  // victim + fill

    logic clk, rst;
    word_t imem_address_i, imem_rdata_o, dmem_address_i, dmem_wdata_i, dmem_rdata_o;
    logic imem_read_i, imem_resp_o, dmem_read_i, dmem_write_i, dmem_resp_o;
    logic [3:0] dmem_wmask_i;
    word_t bmem_address_o;
    logic bmem_read_o, bmem_write_o, bmem_resp_i;
    burst_t bmem_wdata_o, bmem_rdata_i;

    burst_t bmem [word_t];       // sparse burst memory, keyed by beat address
    word_t  model [word_t];      // expected memory words after dmem writes
    word_t  burst_addr_q [$];    // one entry per observed burst
    logic   burst_wr_q [$];
    integer seed = 49444;

    mem_hier_top #(.NUM_SETS(8)) u_mem_hier_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((NUM_ACCESSES * MISS_CYCLES + 30) * 10);
        abort_run("timeout, a port never returned resp");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_burst(input string name, input burst_t got, input burst_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic word_t model_word(input word_t addr);
        word_t a;
        a = {addr[31:2], 2'b00};
        return model.exists(a) ? model[a] : (a ^ FILL_KEY);
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [3:0] mask);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return r;
    endfunction

    function automatic burst_t mem_beat(input word_t a);
        return bmem.exists(a) ? bmem[a] : {(a + 32'd4) ^ FILL_KEY, a ^ FILL_KEY};  // word 0 low
    endfunction

    // burst memory, answers each beat after 0 to 3 idle cycles
    initial begin
        word_t line_addr, a;
        logic  is_wr;
        int    d;
        bmem_resp_i  = 1'b0;
        bmem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (bmem_read_o || bmem_write_o) begin
                line_addr = bmem_address_o;
                is_wr     = bmem_write_o;
                burst_addr_q.push_back(line_addr);
                burst_wr_q.push_back(is_wr);
                for (int beat = 0; beat < BEATS_PER_LINE; beat++) begin
                    d = $unsigned($random(seed)) % 4;
                    @(posedge clk);
                    #1;
                    repeat (d) begin
                        @(posedge clk);
                        #1;
                    end
                    check_flag("bmem_read_o", bmem_read_o, !is_wr);     // held for all beats
                    check_flag("bmem_write_o", bmem_write_o, is_wr);
                    check_word("bmem_address_o", bmem_address_o, line_addr);
                    a = line_addr + 32'(beat * 8);
                    if (is_wr) begin    // writeback beat must match the model line
                        check_burst("bmem_wdata_o", bmem_wdata_o,
                                    {model_word(a + 32'd4), model_word(a)});
                        bmem[a] = bmem_wdata_o;
                    end else begin
                        bmem_rdata_i = mem_beat(a);
                    end
                    bmem_resp_i = 1'b1;
                    @(posedge clk);
                    #1;
                    bmem_resp_i = 1'b0;
                end
            end
        end
    end

    task automatic dmem_access(input word_t addr, input logic wr, input logic [3:0] mask,
                               input word_t wdata, output word_t rdata);
        @(posedge clk);
        #1;
        dmem_address_i = addr;
        dmem_read_i    = !wr;
        dmem_write_i   = wr;
        dmem_wmask_i   = mask;
        dmem_wdata_i   = wdata;
        @(negedge clk);
        while (!dmem_resp_o) @(negedge clk);    // held until resp
        rdata = dmem_rdata_o;
        @(posedge clk);
        #1;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
    endtask

    task automatic dmem_write(input word_t addr, input logic [3:0] mask, input word_t wdata);
        word_t unused;
        model[{addr[31:2], 2'b00}] = merge_bytes(model_word(addr), wdata, mask);
        dmem_access(addr, 1'b1, mask, wdata, unused);
    endtask

    task automatic imem_read(input word_t addr, output word_t rdata);
        @(posedge clk);
        #1;
        imem_address_i = addr;
        imem_read_i    = 1'b1;
        @(negedge clk);
        while (!imem_resp_o) @(negedge clk);
        rdata = imem_rdata_o;
        @(posedge clk);
        #1;
        imem_read_i = 1'b0;
    endtask

    task automatic expect_burst(input int idx, input logic is_wr, input word_t addr);
        check_flag("bmem_write_o", burst_wr_q[idx], is_wr);
        check_word("bmem_address_o", burst_addr_q[idx], addr);
    endtask

    task automatic reset_idle();
        repeat (4) begin
            @(negedge clk);
            check_flag("imem_resp_o", imem_resp_o, 1'b0);
            check_flag("dmem_resp_o", dmem_resp_o, 1'b0);
            check_flag("bmem_read_o", bmem_read_o, 1'b0);
            check_flag("bmem_write_o", bmem_write_o, 1'b0);
        end
    endtask

    task automatic read_miss_then_hit();
        word_t w;
        burst_addr_q.delete();
        burst_wr_q.delete();
        dmem_access(32'h0000_1004, 1'b0, 4'h0, '0, w);
        check_word("dmem_rdata_o", w, model_word(32'h0000_1004));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd1);
        expect_burst(0, 1'b0, 32'h0000_1000);
        dmem_access(32'h0000_1010, 1'b0, 4'h0, '0, w);    // same line, hit
        check_word("dmem_rdata_o", w, model_word(32'h0000_1010));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd1);
        imem_read(32'h0000_2008, w);
        check_word("imem_rdata_o", w, model_word(32'h0000_2008));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd2);
        expect_burst(1, 1'b0, 32'h0000_2000);
        imem_read(32'h0000_201c, w);
        check_word("imem_rdata_o", w, model_word(32'h0000_201c));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd2);
    endtask

    task automatic masked_write_merge();
        word_t w;
        burst_addr_q.delete();
        burst_wr_q.delete();
        dmem_write(32'h0000_1008, 4'b0110, 32'hdead_beef);    // middle two bytes only
        dmem_access(32'h0000_1008, 1'b0, 4'h0, '0, w);
        check_word("dmem_rdata_o", w, model_word(32'h0000_1008));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd0);
    endtask

    task automatic dirty_eviction();
        word_t w;
        dmem_write(32'h0000_3024, 4'b1111, 32'h1234_5678);    // set 1, clean fill then dirty
        burst_addr_q.delete();
        burst_wr_q.delete();
        dmem_access(32'h0000_3124, 1'b0, 4'h0, '0, w);        // same set, other tag
        check_word("dmem_rdata_o", w, model_word(32'h0000_3124));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd2);
        expect_burst(0, 1'b1, 32'h0000_3020);                 // victim goes out first
        expect_burst(1, 1'b0, 32'h0000_3120);
        dmem_access(32'h0000_3024, 1'b0, 4'h0, '0, w);
        check_word("dmem_rdata_o", w, 32'h1234_5678);
    endtask

    task automatic port_contention();
        word_t iw, dw;
        burst_addr_q.delete();
        burst_wr_q.delete();
        fork
            imem_read(32'h0000_4044, iw);
            dmem_access(32'h0000_5068, 1'b0, 4'h0, '0, dw);
        join
        check_word("imem_rdata_o", iw, model_word(32'h0000_4044));
        check_word("dmem_rdata_o", dw, model_word(32'h0000_5068));
        check_word("burst count", word_t'(burst_addr_q.size()), 32'd2);
        expect_burst(0, 1'b0, 32'h0000_5060);    // data side wins
        expect_burst(1, 1'b0, 32'h0000_4040);
    endtask

    initial begin
        rst            = 1'b1;
        imem_address_i = '0;
        imem_read_i    = 1'b0;
        dmem_address_i = '0;
        dmem_read_i    = 1'b0;
        dmem_write_i   = 1'b0;
        dmem_wmask_i   = 4'h0;
        dmem_wdata_i   = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_idle();
        read_miss_then_hit();
        masked_write_merge();
        dirty_eviction();
        port_contention();
        $display("Simulation passed");
        $finish;
    end

endmodule : mem_hier_tb

//--- verilog/mem_hier_top.sv
`timescale 1ns/1ps

module mem_hier_top
    import mem_bus_pkg::*;
#(
    parameter int NUM_SETS = 8
) (
    input  logic       clk,
    input  logic       rst,
    // instruction port
    input  word_t      imem_address_i,
    input  logic       imem_read_i,
    output word_t      imem_rdata_o,
    output logic       imem_resp_o,
    // data port
    input  word_t      dmem_address_i,
    input  logic       dmem_read_i,
    input  logic       dmem_write_i,
    input  logic [3:0] dmem_wmask_i,
    input  word_t      dmem_wdata_i,
    output word_t      dmem_rdata_o,
    output logic       dmem_resp_o,
    // burst memory
    output word_t      bmem_address_o,
    output logic       bmem_read_o,
    output logic       bmem_write_o,
    output burst_t     bmem_wdata_o,
    input  burst_t     bmem_rdata_i,
    input  logic       bmem_resp_i
);

    line_t      imem_line_rdata, imem_line_wdata;     // adapter <-> imem_cache
    line_t      dmem_line_rdata, dmem_line_wdata;     // adapter <-> dmem_cache
    line_mask_t imem_line_mask, dmem_line_mask;

    word_t ipmem_address, dpmem_address, pmem_address;
    logic  ipmem_read, ipmem_write, ipmem_resp;       // imem_cache <-> arbiter
    logic  dpmem_read, dpmem_write, dpmem_resp;       // dmem_cache <-> arbiter
    logic  pmem_read, pmem_write, pmem_resp;          // arbiter <-> cacheline_adaptor
    line_t ipmem_wdata, ipmem_rdata, dpmem_wdata, dpmem_rdata, pmem_wdata, pmem_rdata;

    bus_adapter imem_bus_adapter (
        .address_i    (imem_address_i),  .wdata_i     (32'b0),  // fetch never writes
        .byte_mask_i  (4'b1111),         .line_rdata_i (imem_line_rdata),
        .rdata_o      (imem_rdata_o),    .line_wdata_o (imem_line_wdata),
        .line_mask_o  (imem_line_mask)
    );

    bus_adapter dmem_bus_adapter (
        .address_i    (dmem_address_i),  .wdata_i      (dmem_wdata_i),
        .byte_mask_i  (dmem_wmask_i),    .line_rdata_i (dmem_line_rdata),
        .rdata_o      (dmem_rdata_o),    .line_wdata_o (dmem_line_wdata),
        .line_mask_o  (dmem_line_mask)
    );

    cache #(.NUM_SETS(NUM_SETS)) imem_cache (.clk, .rst,
        .mem_address_i  (imem_address_i),  .mem_read_i (imem_read_i),
        .mem_write_i    (1'b0),            .mem_byte_enable_i (imem_line_mask),
        .mem_wdata_i    (imem_line_wdata), .mem_rdata_o (imem_line_rdata),
        .mem_resp_o     (imem_resp_o),     .pmem_address_o (ipmem_address),
        .pmem_read_o    (ipmem_read),      .pmem_write_o (ipmem_write),
        .pmem_wdata_o   (ipmem_wdata),     .pmem_rdata_i (ipmem_rdata),
        .pmem_resp_i    (ipmem_resp)
    );

    cache #(.NUM_SETS(NUM_SETS)) dmem_cache (.clk, .rst,
        .mem_address_i  (dmem_address_i),  .mem_read_i (dmem_read_i),
        .mem_write_i    (dmem_write_i),    .mem_byte_enable_i (dmem_line_mask),
        .mem_wdata_i    (dmem_line_wdata), .mem_rdata_o (dmem_line_rdata),
        .mem_resp_o     (dmem_resp_o),     .pmem_address_o (dpmem_address),
        .pmem_read_o    (dpmem_read),      .pmem_write_o (dpmem_write),
        .pmem_wdata_o   (dpmem_wdata),     .pmem_rdata_i (dpmem_rdata),
        .pmem_resp_i    (dpmem_resp)
    );

    arbiter arbiter (.clk, .rst,
        .ipmem_address_i (ipmem_address), .ipmem_read_i (ipmem_read),
        .ipmem_write_i   (ipmem_write),   .ipmem_wdata_i (ipmem_wdata),
        .ipmem_rdata_o   (ipmem_rdata),   .ipmem_resp_o (ipmem_resp),
        .dpmem_address_i (dpmem_address), .dpmem_read_i (dpmem_read),
        .dpmem_write_i   (dpmem_write),   .dpmem_wdata_i (dpmem_wdata),
        .dpmem_rdata_o   (dpmem_rdata),   .dpmem_resp_o (dpmem_resp),
        .pmem_address_o  (pmem_address),  .pmem_read_o (pmem_read),
        .pmem_write_o    (pmem_write),    .pmem_wdata_o (pmem_wdata),
        .pmem_rdata_i    (pmem_rdata),    .pmem_resp_i (pmem_resp)
    );

    cacheline_adaptor cacheline_adaptor (.clk, .rst,
        .address_i (pmem_address),   .line_i  (pmem_wdata),
        .read_i    (pmem_read),      .write_i (pmem_write),
        .line_o    (pmem_rdata),     .resp_o  (pmem_resp),
        .address_o (bmem_address_o), .burst_o (bmem_wdata_o),      // to burst memory
        .read_o    (bmem_read_o),    .write_o (bmem_write_o),
        .burst_i   (bmem_rdata_i),   .resp_i  (bmem_resp_i)
    );

endmodule : mem_hier_top

//--- verilog/cacheline_adaptor.sv
`timescale 1ns/1ps

module cacheline_adaptor
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // line side
    input  logic [31:0] address_i,
    input  line_t       line_i,
    input  logic        read_i,
    input  logic        write_i,
    output line_t       line_o,
    output logic        resp_o,
    // burst memory side
    output logic [31:0] address_o,
    output burst_t      burst_o,
    output logic        read_o,
    output logic        write_o,
    input  burst_t      burst_i,
    input  logic        resp_i
);

    localparam int CNT_W = $clog2(BEATS_PER_LINE);

    adaptor_state_t   state_q;
    logic [CNT_W-1:0] beat_q;      // current beat
    logic [31:0]      addr_q;
    line_t            line_q;      // assembled or outgoing line
    logic             last_beat;

    assign last_beat = (beat_q == CNT_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ADP_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ADP_IDLE: begin
                    beat_q <= '0;
                    if (read_i) begin
                        state_q <= ADP_READ;
                    end else if (write_i) begin
                        state_q <= ADP_WRITE;
                    end
                end
                ADP_READ, ADP_WRITE: begin
                    if (resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= ADP_RESP;    // resp one cycle later
                        end
                    end
                end
                ADP_RESP: state_q <= ADP_IDLE;
                default:  state_q <= ADP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ADP_IDLE && (read_i || write_i)) begin
            addr_q <= address_i;
            if (!read_i) begin
                line_q <= line_i;    // outgoing line
            end
        end
        if (state_q == ADP_READ && resp_i) begin
            line_q.bursts[beat_q] <= burst_i;
        end
    end

    assign address_o = addr_q;
    assign burst_o   = line_q.bursts[beat_q];
    assign read_o    = (state_q == ADP_READ);
    assign write_o   = (state_q == ADP_WRITE);
    assign resp_o    = (state_q == ADP_RESP);
    assign line_o    = line_q;

endmodule : cacheline_adaptor

//--- verilog/arbiter.sv
`timescale 1ns/1ps

module arbiter
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // instruction cache
    input  logic [31:0] ipmem_address_i,
    input  logic        ipmem_read_i,
    input  logic        ipmem_write_i,
    input  line_t       ipmem_wdata_i,
    output line_t       ipmem_rdata_o,
    output logic        ipmem_resp_o,
    // data cache
    input  logic [31:0] dpmem_address_i,
    input  logic        dpmem_read_i,
    input  logic        dpmem_write_i,
    input  line_t       dpmem_wdata_i,
    output line_t       dpmem_rdata_o,
    output logic        dpmem_resp_o,
    // shared port to burst adaptor
    output logic [31:0] pmem_address_o,
    output logic        pmem_read_o,
    output logic        pmem_write_o,
    output line_t       pmem_wdata_o,
    input  line_t       pmem_rdata_i,
    input  logic        pmem_resp_i
);

    arb_state_t state_q;
    logic       serve_i, serve_d;

    assign serve_i = (state_q == ARB_SERVE_I);
    assign serve_d = (state_q == ARB_SERVE_D);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (dpmem_read_i || dpmem_write_i) begin
                        state_q <= ARB_SERVE_D;    // data first
                    end else if (ipmem_read_i || ipmem_write_i) begin
                        state_q <= ARB_SERVE_I;
                    end
                end
                ARB_SERVE_I, ARB_SERVE_D: begin
                    if (pmem_resp_i) begin
                        state_q <= ARB_IDLE;       // release after resp
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // forward only the granted side, nothing while idle
    assign pmem_address_o = serve_d ? dpmem_address_i : ipmem_address_i;
    assign pmem_wdata_o   = serve_d ? dpmem_wdata_i : ipmem_wdata_i;
    assign pmem_read_o    = (serve_d && dpmem_read_i) || (serve_i && ipmem_read_i);
    assign pmem_write_o   = (serve_d && dpmem_write_i) || (serve_i && ipmem_write_i);

    assign ipmem_resp_o  = serve_i && pmem_resp_i;
    assign dpmem_resp_o  = serve_d && pmem_resp_i;
    assign ipmem_rdata_o = serve_i ? pmem_rdata_i : '0;
    assign dpmem_rdata_o = serve_d ? pmem_rdata_i : '0;

endmodule : arbiter

//--- verilog/cache.sv
`timescale 1ns/1ps

module cache
    import mem_bus_pkg::*;
    import mem_ctrl_pkg::*;
#(
    parameter int NUM_SETS = 8
) (
    input  logic        clk,
    input  logic        rst,
    // core side
    input  logic [31:0] mem_address_i,
    input  logic        mem_read_i,
    input  logic        mem_write_i,
    input  line_mask_t  mem_byte_enable_i,
    input  line_t       mem_wdata_i,
    output line_t       mem_rdata_o,
    output logic        mem_resp_o,
    // line port toward arbiter
    output logic [31:0] pmem_address_o,
    output logic        pmem_read_o,
    output logic        pmem_write_o,
    output line_t       pmem_wdata_o,
    input  line_t       pmem_rdata_i,
    input  logic        pmem_resp_i
);

    localparam int OFF_W = 5;                      // 32-byte line
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    cache_state_t state_q, state_d;

    // registered request
    logic [31:0] req_addr_q;
    logic        req_write_q;
    line_t       req_wdata_q;
    line_mask_t  req_mask_q;

    // arrays
    logic [TAG_W-1:0] tag_q [NUM_SETS];
    line_t            data_q [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic             hit;
    line_t            merged;     // stored line with write bytes applied

    assign req_idx = req_addr_q[OFF_W +: IDX_W];
    assign req_tag = req_addr_q[31 -: TAG_W];
    assign hit     = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    always_comb begin
        merged = data_q[req_idx];
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (req_mask_q[w*4 + b]) begin
                    merged.words[w][b*8 +: 8] = req_wdata_q.words[w][b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        state_d        = state_q;
        mem_resp_o     = 1'b0;
        mem_rdata_o    = data_q[req_idx];
        pmem_read_o    = 1'b0;
        pmem_write_o   = 1'b0;
        pmem_wdata_o   = data_q[req_idx];                        // victim line
        pmem_address_o = {req_tag, req_idx, {OFF_W{1'b0}}};      // fill address
        case (state_q)
            CACHE_IDLE: begin
                if (mem_read_i || mem_write_i) begin
                    state_d = CACHE_COMPARE;
                end
            end
            CACHE_COMPARE: begin
                if (hit) begin
                    mem_resp_o = 1'b1;
                    state_d    = CACHE_IDLE;
                end else if (valid_q[req_idx] && dirty_q[req_idx]) begin
                    state_d = CACHE_WRITEBACK;
                end else begin
                    state_d = CACHE_ALLOCATE;
                end
            end
            CACHE_WRITEBACK: begin
                pmem_write_o   = 1'b1;
                pmem_address_o = {tag_q[req_idx], req_idx, {OFF_W{1'b0}}};  // old line
                if (pmem_resp_i) begin
                    state_d = CACHE_ALLOCATE;
                end
            end
            CACHE_ALLOCATE: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    state_d = CACHE_COMPARE;    // retry as a hit
                end
            end
            default: state_d = CACHE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= CACHE_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == CACHE_COMPARE && hit && req_write_q) begin
                dirty_q[req_idx] <= 1'b1;
            end else if (state_q == CACHE_ALLOCATE && pmem_resp_i) begin
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= 1'b0;    // fresh from memory
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CACHE_IDLE && (mem_read_i || mem_write_i)) begin
            req_addr_q  <= mem_address_i;
            req_write_q <= mem_write_i;
            req_wdata_q <= mem_wdata_i;
            req_mask_q  <= mem_byte_enable_i;
        end
        if (state_q == CACHE_COMPARE && hit && req_write_q) begin
            data_q[req_idx] <= merged;
        end
        if (state_q == CACHE_ALLOCATE && pmem_resp_i) begin
            data_q[req_idx] <= pmem_rdata_i;
            tag_q[req_idx]  <= req_tag;
        end
    end

endmodule : cache

//--- verilog/bus_adapter.sv
`timescale 1ns/1ps

module bus_adapter
    import mem_bus_pkg::*;
(
    input  word_t      address_i,     // core byte address
    input  word_t      wdata_i,
    input  logic [3:0] byte_mask_i,
    input  line_t      line_rdata_i,  // line from cache
    output word_t      rdata_o,
    output line_t      line_wdata_o,  // write word in every slot
    output line_mask_t line_mask_o
);

    logic [2:0] word_sel;    // word offset within line

    assign word_sel = address_i[4:2];

    // cache merges only masked bytes, so replicating is enough
    assign line_wdata_o.words = {WORDS_PER_LINE{wdata_i}};

    assign rdata_o = line_rdata_i.words[word_sel];

    always_comb begin
        line_mask_o = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (word_sel == 3'(w)) begin
                line_mask_o[w*4 +: 4] = byte_mask_i;    // 4 bytes per word
            end
        end
    end

endmodule : bus_adapter

//--- verilog/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // cache controller
    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_COMPARE,      // tag check, hit response
        CACHE_WRITEBACK,    // dirty victim out
        CACHE_ALLOCATE      // line fill
    } cache_state_t;

    // line port arbiter
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVE_I,
        ARB_SERVE_D
    } arb_state_t;

    // burst adaptor
    typedef enum logic [1:0] {
        ADP_IDLE,
        ADP_READ,           // collecting beats
        ADP_WRITE,          // sending beats
        ADP_RESP            // line resp to arbiter
    } adaptor_state_t;

endpackage : mem_ctrl_pkg

//--- verilog/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int WORD_W         = 32;    // core data word
    localparam int BURST_W        = 64;    // one memory beat
    localparam int WORDS_PER_LINE = 8;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_BYTES     = 32;    // 256-bit line

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BURST_W-1:0] burst_t;

    typedef logic [LINE_BYTES-1:0] line_mask_t;    // one bit per line byte

    // same 256 bits, word view for cache side, beat view for memory side
    typedef union packed {
        word_t  [WORDS_PER_LINE-1:0] words;    // word 0 at lsb
        burst_t [BEATS_PER_LINE-1:0] bursts;   // beat 0 at lsb
    } line_t;

endpackage : mem_bus_pkg
